// File: verilog/uart_defines.svh
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// data bits carried by one frame
`define UART_DATA_W 8

// tx_clk cycles between two sample ticks
`define UART_CLKS_PER_SAMPLE 2

// sample ticks per bit, so one bit lasts 16 clocks
`define UART_SAMPLES_PER_BIT 8

// flops in the rx input synchronizer
`define UART_SYNC_STAGES 3

// 0 = even parity, 1 = odd parity
`define UART_PARITY_ODD 0

`endif

// File: verilog/uart_frame_pkg.sv
`default_nettype none

`include "uart_defines.svh"

package uart_frame_pkg;

	// start + data + parity + stop
	localparam int UART_FRAME_BITS = `UART_DATA_W + 3;

	typedef logic [`UART_DATA_W-1:0] uart_data_t;      // one data byte
	typedef logic [UART_FRAME_BITS-1:0] uart_frame_t;  // frame in send order, bit 0 goes first
	typedef logic [3:0] uart_bit_idx_t;                // bit position inside a frame

	// parity bit for a byte, same rule on both sides of the link
	function automatic logic uart_parity(input uart_data_t data);
		logic par;
		par = ^data;                              // even parity
		if (`UART_PARITY_ODD != 0) begin
			par = ~par;                           // odd parity flips it
		end
		return par;
	endfunction

endpackage

`default_nettype wire

// File: verilog/uart_ctrl_pkg.sv
`default_nettype none

`include "uart_defines.svh"

package uart_ctrl_pkg;

	typedef enum logic {
		TX_IDLE,   // line held at stop level
		TX_SEND    // shifting the frame out
	} tx_state_t;

	typedef enum logic [2:0] {
		RX_IDLE,   // waiting for start_seen
		RX_START,  // start bit confirmed, data bit 0 next
		RX_DATA,   // collecting data bits 1..7
		RX_PARITY, // parity bit next
		RX_STOP    // stop bit next, then judge
	} rx_state_t;

	typedef logic [$clog2(`UART_SAMPLES_PER_BIT)-1:0] sample_cnt_t;  // sample ticks in a bit
	typedef logic [$clog2(`UART_CLKS_PER_SAMPLE)-1:0] clk_div_t;     // clocks in a sample

endpackage

`default_nettype wire

// File: verilog/uart_rx_sample_if.sv
`default_nettype none

interface uart_rx_sample_if;

	logic rx_bit;      // synchronized serial level
	logic bit_strobe;  // one-cycle pulse at each bit centre after start
	logic start_seen;  // one-cycle pulse, start bit still low at its centre
	logic in_frame;    // deframer busy with a frame

	// front drives the strobes and listens to in_frame
	modport front (output rx_bit, output bit_strobe, output start_seen, input in_frame);

	modport deframer (input rx_bit, input bit_strobe, input start_seen, output in_frame);

endinterface

`default_nettype wire

// File: verilog/uart_baud_gen.sv
`default_nettype none

`include "uart_defines.svh"

module uart_baud_gen (
	input  wire  i_tx_clk,
	input  wire  i_reset_tx,
	output logic o_sample_tick,  // one pulse every UART_CLKS_PER_SAMPLE clocks
	output logic o_bit_tick      // every UART_SAMPLES_PER_BIT-th sample tick
);
	import uart_ctrl_pkg::*;

	localparam clk_div_t    DIV_LAST  = clk_div_t'(`UART_CLKS_PER_SAMPLE - 1);
	localparam sample_cnt_t TICK_LAST = sample_cnt_t'(`UART_SAMPLES_PER_BIT - 1);

	clk_div_t    div_cnt;   // clocks inside the current sample
	sample_cnt_t tick_cnt;  // sample ticks inside the current bit

	always_ff @(posedge i_tx_clk) begin
		if (i_reset_tx) begin
			div_cnt  <= '0;
			tick_cnt <= '0;
		end else if (div_cnt == DIV_LAST) begin
			div_cnt  <= '0;
			tick_cnt <= (tick_cnt == TICK_LAST) ? '0 : tick_cnt + 1'b1;  // wrap at bit end
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	assign o_sample_tick = (div_cnt == DIV_LAST);
	assign o_bit_tick    = o_sample_tick && (tick_cnt == TICK_LAST);  // last sample of the bit

endmodule

`default_nettype wire

// File: verilog/uart_tx.sv
`default_nettype none

module uart_tx (
	input  wire                       i_tx_clk,
	input  wire                       i_reset_tx,
	input  wire                       i_bit_tick,  // bit boundary from the divider
	input  wire                       i_enable,    // load request, taken only when idle
	input  wire uart_frame_pkg::uart_data_t i_data,
	output logic                      o_busy,
	output logic                      o_serial
);
	import uart_frame_pkg::*;
	import uart_ctrl_pkg::*;

	// index reached after the stop bit has gone out
	localparam uart_bit_idx_t END_IDX = uart_bit_idx_t'(UART_FRAME_BITS);

	tx_state_t     state;
	uart_frame_t   shift_reg;  // remaining bits, lsb is next on the line
	uart_bit_idx_t bit_idx;    // bits already driven onto o_serial

	logic accept;              // enable taken this cycle
	logic advance;             // bit boundary while sending

	assign accept  = (state == TX_IDLE) && i_enable;
	assign advance = (state == TX_SEND) && i_bit_tick;

	always_ff @(posedge i_tx_clk) begin
		if (i_reset_tx) begin
			state    <= TX_IDLE;
			bit_idx  <= '0;
			o_serial <= 1'b1;                // idle line is high
		end else begin
			case (state)
				TX_IDLE: begin
					if (i_enable) begin
						state   <= TX_SEND;
						bit_idx <= '0;
					end
				end
				TX_SEND: begin
					if (i_bit_tick) begin
						if (bit_idx == END_IDX) begin
							state <= TX_IDLE;    // stop bit done, line stays high
						end else begin
							o_serial <= shift_reg[0];
							bit_idx  <= bit_idx + 1'b1;
						end
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// frame is {stop, parity, data, start}, shifted right with ones filling in
	always_ff @(posedge i_tx_clk) begin
		if (accept) begin
			shift_reg <= {1'b1, uart_parity(i_data), i_data, 1'b0};
		end else if (advance) begin
			shift_reg <= {1'b1, shift_reg[UART_FRAME_BITS-1:1]};
		end
	end

	assign o_busy = (state == TX_SEND);   // rises the cycle after accept

endmodule

`default_nettype wire

// File: verilog/uart_rx_front.sv
`default_nettype none

`include "uart_defines.svh"

module uart_rx_front (
	input  wire                i_tx_clk,
	input  wire                i_reset_tx,
	input  wire                i_sample_tick,
	input  wire                i_serial,   // raw line, asynchronous to us
	uart_rx_sample_if.front    sample
);
	import uart_ctrl_pkg::*;

	localparam int          SYNC_N   = `UART_SYNC_STAGES;
	localparam sample_cnt_t MID_CNT  = sample_cnt_t'(`UART_SAMPLES_PER_BIT / 2 - 1);
	localparam sample_cnt_t LAST_CNT = sample_cnt_t'(`UART_SAMPLES_PER_BIT - 1);

	logic [SYNC_N-1:0] sync_ff;    // msb is the settled level
	logic              rx_prev;    // last settled level, for the edge
	logic              hunting;    // edge seen, waiting for the start centre
	sample_cnt_t       phase_cnt;  // sample ticks since the edge or the last centre

	logic rx_sync;
	logic fall_edge;
	logic searching;               // allowed to look for a new start edge

	assign rx_sync   = sync_ff[SYNC_N-1];
	assign fall_edge = rx_prev && !rx_sync;
	assign searching = !(sample.in_frame || hunting || sample.start_seen);

	assign sample.rx_bit = rx_sync;

	always_ff @(posedge i_tx_clk) begin
		if (i_reset_tx) begin
			sync_ff           <= '1;                   // line idles high
			rx_prev           <= 1'b1;
			hunting           <= 1'b0;
			phase_cnt         <= '0;
			sample.start_seen <= 1'b0;
			sample.bit_strobe <= 1'b0;
		end else begin
			sync_ff           <= {sync_ff[SYNC_N-2:0], i_serial};
			rx_prev           <= rx_sync;
			sample.start_seen <= 1'b0;
			sample.bit_strobe <= 1'b0;
			if (fall_edge && searching) begin
				hunting   <= 1'b1;                       // phase restarts at the edge
				phase_cnt <= '0;
			end else if (i_sample_tick) begin
				phase_cnt <= (phase_cnt == LAST_CNT) ? '0 : phase_cnt + 1'b1;
				if (hunting && phase_cnt == MID_CNT) begin
					hunting           <= 1'b0;
					phase_cnt         <= '0;             // bit centres from here on
					sample.start_seen <= !rx_sync;       // a glitch is dropped quietly
				end else if (sample.in_frame && phase_cnt == LAST_CNT) begin
					sample.bit_strobe <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/uart_rx_deframer.sv
`default_nettype none

`include "uart_defines.svh"

module uart_rx_deframer (
	input  wire                         i_tx_clk,
	input  wire                         i_reset_tx,
	uart_rx_sample_if.deframer          sample,
	output uart_frame_pkg::uart_data_t  o_received_data,
	output logic                        o_data_valid,
	output logic                        o_rx_error
);
	import uart_frame_pkg::*;
	import uart_ctrl_pkg::*;

	localparam uart_bit_idx_t LAST_DATA = uart_bit_idx_t'(`UART_DATA_W - 1);

	rx_state_t     state;
	uart_data_t    shift_reg;   // data bits, lsb arrives first
	uart_bit_idx_t bit_idx;     // next data bit to be stored
	logic          par_bit;     // parity as seen on the line

	logic frame_ok;             // parity matches and stop is high

	assign frame_ok        = (par_bit == uart_parity(shift_reg)) && sample.rx_bit;
	assign sample.in_frame = (state != RX_IDLE);

	always_ff @(posedge i_tx_clk) begin
		if (i_reset_tx) begin
			state        <= RX_IDLE;
			bit_idx      <= '0;
			o_data_valid <= 1'b0;
			o_rx_error   <= 1'b0;
		end else begin
			o_data_valid <= 1'b0;
			o_rx_error   <= 1'b0;
			case (state)
				RX_IDLE: begin
					if (sample.start_seen) state <= RX_START;
				end
				RX_START: begin
					if (sample.bit_strobe) begin
						bit_idx <= uart_bit_idx_t'(1);   // bit 0 taken here
						state   <= RX_DATA;
					end
				end
				RX_DATA: begin
					if (sample.bit_strobe) begin
						if (bit_idx == LAST_DATA) state <= RX_PARITY;
						else bit_idx <= bit_idx + 1'b1;
					end
				end
				RX_PARITY: begin
					if (sample.bit_strobe) state <= RX_STOP;
				end
				RX_STOP: begin
					if (sample.bit_strobe) begin
						o_data_valid <= frame_ok;        // exactly one of the two pulses
						o_rx_error   <= !frame_ok;
						state        <= RX_IDLE;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// payload path
	always_ff @(posedge i_tx_clk) begin
		if (sample.bit_strobe && (state == RX_START || state == RX_DATA)) begin
			shift_reg <= {sample.rx_bit, shift_reg[`UART_DATA_W-1:1]};
		end
		if (sample.bit_strobe && state == RX_PARITY) begin
			par_bit <= sample.rx_bit;
		end
		if (sample.bit_strobe && state == RX_STOP && frame_ok) begin
			o_received_data <= shift_reg;             // bad frames leave the old byte
		end
	end

endmodule

`default_nettype wire

// File: verilog/uart_top.sv
`default_nettype none

module uart_top (
	input  wire                         i_tx_clk,
	input  wire                         i_reset_tx,
	input  wire                         i_enable,
	input  wire uart_frame_pkg::uart_data_t i_data,
	output logic                        o_busy,
	output logic                        o_serial,
	input  wire                         i_serial,    // looped back outside the design
	output uart_frame_pkg::uart_data_t  o_received_data,
	output logic                        o_data_valid,
	output logic                        o_rx_error
);

	logic sample_tick;  // shared divider outputs
	logic bit_tick;

	uart_rx_sample_if sample_if ();

	uart_baud_gen u_baud_gen (
		.i_tx_clk      (i_tx_clk),
		.i_reset_tx    (i_reset_tx),
		.o_sample_tick (sample_tick),
		.o_bit_tick    (bit_tick)
	);

	uart_tx u_tx (
		.i_tx_clk   (i_tx_clk),
		.i_reset_tx (i_reset_tx),
		.i_bit_tick (bit_tick),
		.i_enable   (i_enable),
		.i_data     (i_data),
		.o_busy     (o_busy),
		.o_serial   (o_serial)
	);

	uart_rx_front u_rx_front (
		.i_tx_clk      (i_tx_clk),
		.i_reset_tx    (i_reset_tx),
		.i_sample_tick (sample_tick),  // rx keeps its own phase, no bit_tick
		.i_serial      (i_serial),
		.sample        (sample_if.front)
	);

	uart_rx_deframer u_rx_deframer (
		.i_tx_clk        (i_tx_clk),
		.i_reset_tx      (i_reset_tx),
		.sample          (sample_if.deframer),
		.o_received_data (o_received_data),
		.o_data_valid    (o_data_valid),
		.o_rx_error      (o_rx_error)
	);

endmodule

`default_nettype wire

// File: tests/uart_chk.sv
`default_nettype none

`include "uart_defines.svh"

module uart_chk (
	input wire       i_tx_clk,
	input wire       i_reset_tx,
	input wire       i_enable,
	input wire [7:0] i_data,
	input wire       o_busy,
	input wire       o_serial,
	input wire       bit_tick,         // divider output inside the top level
	input wire [7:0] o_received_data,
	input wire       o_data_valid,
	input wire       o_rx_error
);
	timeunit 1ns;
	timeprecision 100ps;

	int          fail_count;           // polled by the testbench
	int          accept_cnt;           // frames taken by tx
	int          valid_cnt;            // good frames seen by rx
	logic [7:0]  exp_byte;             // byte of the last accepted frame
	logic [10:0] exp_frame;            // {stop, parity, data, start}
	logic [3:0]  tx_idx;               // frame bits started on the line
	logic        exp_line;
	logic        accept;
	logic        par;

	assign accept   = i_enable && !o_busy;
	assign par      = (^i_data) ^ (`UART_PARITY_ODD != 0);  // even unless odd chosen
	assign exp_line = (tx_idx == 4'd0) ? 1'b1 : exp_frame[tx_idx - 4'd1];

	initial fail_count = 0;

	always_ff @(posedge i_tx_clk) begin
		if (i_reset_tx) begin
			accept_cnt <= 0;
			valid_cnt  <= 0;
			tx_idx     <= '0;
		end else begin
			if (accept) begin
				exp_byte   <= i_data;
				exp_frame  <= {1'b1, par, i_data, 1'b0};
				tx_idx     <= '0;
				accept_cnt <= accept_cnt + 1;
			end else if (o_busy && bit_tick && tx_idx != 4'd11) begin
				tx_idx <= tx_idx + 4'd1;   // next frame bit goes out
			end
			if (o_data_valid) valid_cnt <= valid_cnt + 1;
		end
	end

	a_reset_state: assert property (@(posedge i_tx_clk)
		i_reset_tx |=> !o_busy && !o_data_valid && !o_rx_error && o_serial)
		else begin
			$error("FAIL %0t: outputs wrong after reset", $time);
			fail_count++;
		end

	a_rx_data: assert property (@(posedge i_tx_clk) disable iff (i_reset_tx)
		o_data_valid |-> (o_received_data == exp_byte) && !o_rx_error)
		else begin
			$error("FAIL %0t: received byte mismatch", $time);
			fail_count++;
		end

	a_valid_count: assert property (@(posedge i_tx_clk) disable iff (i_reset_tx)
		o_data_valid |-> (valid_cnt + 1 == accept_cnt))
		else begin
			$error("FAIL %0t: valid pulses do not match enables", $time);
			fail_count++;
		end

	// start bit low for one full bit from the first bit boundary
	a_start_bit: assert property (@(posedge i_tx_clk) disable iff (i_reset_tx)
		$rose(o_busy) |-> bit_tick [->1] ##1 (!o_serial) [*16])
		else begin
			$error("FAIL %0t: start bit timing wrong", $time);
			fail_count++;
		end

	a_line_bits: assert property (@(posedge i_tx_clk) disable iff (i_reset_tx)
		o_busy |-> (o_serial == exp_line))
		else begin
			$error("FAIL %0t: serial bit %0d wrong", $time, tx_idx);
			fail_count++;
		end

	a_idle_high: assert property (@(posedge i_tx_clk) disable iff (i_reset_tx)
		!o_busy |-> o_serial)
		else begin
			$error("FAIL %0t: line low while idle", $time);
			fail_count++;
		end

	a_busy_end: assert property (@(posedge i_tx_clk) disable iff (i_reset_tx)
		$fell(o_busy) |-> $past(bit_tick) && (tx_idx == 4'd11))
		else begin
			$error("FAIL %0t: busy fell off the stop boundary", $time);
			fail_count++;
		end

	a_err_only: assert property (@(posedge i_tx_clk) disable iff (i_reset_tx)
		o_rx_error |-> !o_data_valid && (valid_cnt == accept_cnt))
		else begin
			$error("FAIL %0t: unexpected rx error", $time);
			fail_count++;
		end

	// byte and error pulse are updated on the same edge
	a_err_keeps: assert property (@(posedge i_tx_clk) disable iff (i_reset_tx)
		o_rx_error |-> $stable(o_received_data))
		else begin
			$error("FAIL %0t: byte changed on a bad frame", $time);
			fail_count++;
		end

endmodule

bind uart_top uart_chk chk (
	.i_tx_clk        (i_tx_clk),
	.i_reset_tx      (i_reset_tx),
	.i_enable        (i_enable),
	.i_data          (i_data),
	.o_busy          (o_busy),
	.o_serial        (o_serial),
	.bit_tick        (bit_tick),
	.o_received_data (o_received_data),
	.o_data_valid    (o_data_valid),
	.o_rx_error      (o_rx_error)
);

`default_nettype wire

// File: tests/uart_tb.sv
`default_nettype none

`include "uart_defines.svh"

module uart_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import uart_frame_pkg::*;

	localparam int FRAME_CYC = 176;          // 11 bits of 16 clocks
	localparam int WATCH_CYC = 30 * FRAME_CYC;

	logic       tx_clk;
	logic       reset_tx;
	logic       enable;
	uart_data_t data;
	logic       busy;
	logic       serial_out;
	logic       serial_in;
	uart_data_t rx_data;
	logic       data_valid;
	logic       rx_error;
	logic       inject;                      // testbench owns the line
	logic       inj_bit;
	logic [31:0] lcg_state;

	assign serial_in = inject ? inj_bit : serial_out;  // loopback outside the DUT

	uart_top dut (
		.i_tx_clk        (tx_clk),
		.i_reset_tx      (reset_tx),
		.i_enable        (enable),
		.i_data          (data),
		.o_busy          (busy),
		.o_serial        (serial_out),
		.i_serial        (serial_in),
		.o_received_data (rx_data),
		.o_data_valid    (data_valid),
		.o_rx_error      (rx_error)
	);

	initial begin
		tx_clk = 1'b0;
		forever #2 tx_clk = ~tx_clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic abort_run(input string why);
		$display("ERRORS FOUND");
		$fatal(1, "%s", why);
	endtask

	task automatic next_byte(output uart_data_t b);
		lcg_state = lcg_next(lcg_state);
		b = lcg_state[23:16];                    // upper bits mix better
	endtask

	task automatic wait_pulse(input bit want_err);
		int n;
		for (n = 0; n < 2 * FRAME_CYC; n++) begin
			@(negedge tx_clk);
			if (!want_err && data_valid) return;
			if (want_err && rx_error) return;
		end
		abort_run(want_err ? "no rx error for the corrupted frame"
		                   : "no data valid pulse for a sent frame");
	endtask

	task automatic send_frame(input uart_data_t b);
		uart_data_t junk;
		@(negedge tx_clk);
		while (busy) @(negedge tx_clk);
		@(posedge tx_clk);
		enable <= 1'b1;
		data   <= b;
		@(posedge tx_clk);
		enable <= 1'b0;
		repeat (20) @(posedge tx_clk);
		next_byte(junk);
		enable <= 1'b1;                          // ignored while busy
		data   <= junk;
		@(posedge tx_clk);
		enable <= 1'b0;
		wait_pulse(1'b0);
	endtask

	task automatic inject_bad_frame(input uart_data_t b);
		logic [10:0] frame;
		int i;
		frame = {1'b1, ~((^b) ^ (`UART_PARITY_ODD != 0)), b, 1'b0};  // parity flipped
		@(negedge tx_clk);
		while (busy) @(negedge tx_clk);
		repeat (40) @(posedge tx_clk);
		inject <= 1'b1;
		for (i = 0; i < 10; i++) begin
			inj_bit <= frame[i];
			repeat (16) @(posedge tx_clk);
		end
		inj_bit <= frame[10];                    // stop bit, judged at its centre
		wait_pulse(1'b1);
		repeat (20) @(posedge tx_clk);
		inject <= 1'b0;
	endtask

	// any failed assertion ends the run right away
	always @(negedge tx_clk) begin
		if (dut.chk.fail_count != 0) abort_run("assertion failure in the checker");
	end

	initial begin
		repeat (WATCH_CYC) @(posedge tx_clk);
		abort_run("watchdog timeout, test did not finish");
	end

	initial begin
		uart_data_t b;
		int k;
		reset_tx  = 1'b1;
		enable    = 1'b0;
		data      = '0;
		inject    = 1'b0;
		inj_bit   = 1'b1;
		lcg_state = 32'd90200;
		repeat (10) @(posedge tx_clk);
		reset_tx <= 1'b0;
		for (k = 0; k < 20; k++) begin
			next_byte(b);
			send_frame(b);
		end
		next_byte(b);
		inject_bad_frame(b);
		repeat (10) @(negedge tx_clk);
		if (dut.chk.fail_count == 0) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			abort_run("checker counted failures");
		end
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+verilog
verilog/uart_frame_pkg.sv
verilog/uart_ctrl_pkg.sv
verilog/uart_rx_sample_if.sv
verilog/uart_baud_gen.sv
verilog/uart_tx.sv
verilog/uart_rx_front.sv
verilog/uart_rx_deframer.sv
verilog/uart_top.sv
tests/uart_chk.sv
tests/uart_tb.sv

// File: run.sh
#!/bin/sh
# build and run the UART testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 -f src.f --top-module uart_tb -o uart_sim
./obj_dir/uart_sim +verilator+error+limit+100
